//--- common/cmac_mon_pkg.sv
package cmac_mon_pkg;

    localparam int cnt_width_default = 32;
    localparam int apb_addr_width    = 8;

    // Bit positions inside CTRL
    localparam int ctrl_clear_rx_bit = 0;
    localparam int ctrl_clear_tx_bit = 1;

    // Packet in progress or not
    typedef enum logic [0:0] {
        MON_IDLE = 1'b0,
        MON_BUSY = 1'b1
    } mon_state_e;

    // Register byte addresses
    typedef enum logic [apb_addr_width-1:0] {
        RX_PKT   = 8'h00,
        RX_LOST  = 8'h04,
        RX_BEATS = 8'h08,
        TX_PKT   = 8'h0C,
        TX_SIZE  = 8'h10,
        TX_BEATS = 8'h14,
        STATUS   = 8'h18,
        CTRL     = 8'h1C
    } stat_addr_e;

endpackage

//--- common/mon_stats_if.sv
interface mon_stats_if
    import cmac_mon_pkg::*;
#(
    parameter int CNT_WIDTH = cnt_width_default
);

    logic [CNT_WIDTH-1:0] pkt_count;
    logic [CNT_WIDTH-1:0] aux_count;  // Lost beats on rx, last packet size on tx
    logic [CNT_WIDTH-1:0] beat_count;
    logic                 idle;
    logic                 clear;      // One-cycle pulse from the register block

    modport monitor (
        output pkt_count,
        output aux_count,
        output beat_count,
        output idle,
        input  clear
    );

    modport regs (
        input  pkt_count,
        input  aux_count,
        input  beat_count,
        input  idle,
        output clear
    );

endinterface

//--- stream_monitor/recv_monitor.sv
module recv_monitor
    import cmac_mon_pkg::*;
#(
    parameter int CNT_WIDTH = cnt_width_default
)(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         valid,
    input  logic         ready,
    input  logic         last,
    mon_stats_if.monitor stats
);

    mon_state_e           state;
    logic [CNT_WIDTH-1:0] pkt_count;
    logic [CNT_WIDTH-1:0] lost_count;
    logic [CNT_WIDTH-1:0] beat_count;

    logic accept;
    logic lost;

    assign accept = valid && ready;
    // MAC rx path cannot stall, so a refused beat is gone
    assign lost   = valid && !ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count  <= '0;
            lost_count <= '0;
            beat_count <= '0;
        end else if (stats.clear) begin  // Clear wins over a beat
            pkt_count  <= '0;
            lost_count <= '0;
            beat_count <= '0;
        end else begin
            if (accept && last)
                pkt_count <= pkt_count + 1'b1;
            if (lost)
                lost_count <= lost_count + 1'b1;
            if (valid)
                beat_count <= beat_count + 1'b1;  // Every offered beat
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MON_IDLE;
        end else if (stats.clear) begin
            state <= MON_IDLE;
        end else if (accept) begin
            state <= last ? MON_IDLE : MON_BUSY;
        end
    end

    assign stats.pkt_count  = pkt_count;
    assign stats.aux_count  = lost_count;
    assign stats.beat_count = beat_count;
    assign stats.idle       = (state == MON_IDLE);

endmodule

//--- stream_monitor/send_monitor.sv
module send_monitor
    import cmac_mon_pkg::*;
#(
    parameter int CNT_WIDTH = cnt_width_default
)(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         valid,
    input  logic         ready,
    input  logic         last,
    mon_stats_if.monitor stats
);

    mon_state_e           state;
    logic [CNT_WIDTH-1:0] pkt_count;
    logic [CNT_WIDTH-1:0] pkt_size;
    logic [CNT_WIDTH-1:0] beat_count;
    logic [CNT_WIDTH-1:0] run_count;  // Beats so far in the current packet

    logic accept;

    assign accept = valid && ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count  <= '0;
            beat_count <= '0;
        end else if (stats.clear) begin
            pkt_count  <= '0;
            beat_count <= '0;
        end else if (accept) begin
            beat_count <= beat_count + 1'b1;
            if (last)
                pkt_count <= pkt_count + 1'b1;
        end
    end

    // Packet length tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_count <= '0;
            pkt_size  <= '0;
        end else if (stats.clear) begin
            run_count <= '0;
            pkt_size  <= '0;
        end else if (accept) begin
            if (last) begin
                pkt_size  <= run_count + 1'b1;  // Include the last beat itself
                run_count <= '0;
            end else begin
                run_count <= run_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MON_IDLE;
        end else if (stats.clear) begin
            state <= MON_IDLE;
        end else if (accept) begin
            state <= last ? MON_IDLE : MON_BUSY;
        end
    end

    assign stats.pkt_count  = pkt_count;
    assign stats.aux_count  = pkt_size;
    assign stats.beat_count = beat_count;
    assign stats.idle       = (state == MON_IDLE);

endmodule

//--- hw/stat_regs.sv
module stat_regs
    import cmac_mon_pkg::*;
#(
    parameter int CNT_WIDTH = cnt_width_default
)(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    mon_stats_if.regs                 rx,
    mon_stats_if.regs                 tx
);

    logic        access;
    logic        addr_hit;
    logic        ctrl_wr;
    logic [31:0] rdata;
    logic        clear_rx;
    logic        clear_tx;

    // Counters are zero-extended onto the 32-bit bus
    function automatic logic [31:0] zext(input logic [CNT_WIDTH-1:0] value);
        return 32'(value);
    endfunction

    assign access = psel && penable;
    assign pready = access;  // No wait states
    assign ctrl_wr = access && pwrite && (paddr == CTRL);

    // Read mux
    always_comb begin
        rdata    = '0;
        addr_hit = 1'b1;
        case (paddr)
            RX_PKT:   rdata = zext(rx.pkt_count);
            RX_LOST:  rdata = zext(rx.aux_count);
            RX_BEATS: rdata = zext(rx.beat_count);
            TX_PKT:   rdata = zext(tx.pkt_count);
            TX_SIZE:  rdata = zext(tx.aux_count);
            TX_BEATS: rdata = zext(tx.beat_count);
            STATUS: begin
                rdata[0] = rx.idle;
                rdata[1] = tx.idle;
            end
            CTRL:     rdata = '0;  // Write-only pulses
            default:  addr_hit = 1'b0;
        endcase
    end

    // Counter values are the ones before any beat on this edge
    assign prdata = (access && !pwrite) ? rdata : '0;

    // Unknown address, or a write anywhere but CTRL
    assign pslverr = access && (!addr_hit || (pwrite && (paddr != CTRL)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clear_rx <= 1'b0;
            clear_tx <= 1'b0;
        end else begin
            clear_rx <= ctrl_wr && pwdata[ctrl_clear_rx_bit];
            clear_tx <= ctrl_wr && pwdata[ctrl_clear_tx_bit];
        end
    end

    assign rx.clear = clear_rx;
    assign tx.clear = clear_tx;

endmodule

//--- hw/cmac_stream_monitor.sv
module cmac_stream_monitor
    import cmac_mon_pkg::*;
#(
    parameter int CNT_WIDTH = cnt_width_default
)(
    input  logic                      clk,
    input  logic                      rst_n,

    // Receive stream, observed only
    input  logic                      rx_valid,
    input  logic                      rx_ready,
    input  logic                      rx_last,

    // Transmit stream, observed only
    input  logic                      tx_valid,
    input  logic                      tx_ready,
    input  logic                      tx_last,

    // APB slave
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);

    mon_stats_if #(.CNT_WIDTH(CNT_WIDTH)) rx_stats ();
    mon_stats_if #(.CNT_WIDTH(CNT_WIDTH)) tx_stats ();

    recv_monitor #(
        .CNT_WIDTH (CNT_WIDTH)
    ) recv_monitor_i (
        .clk   (clk     ),
        .rst_n (rst_n   ),
        .valid (rx_valid),
        .ready (rx_ready),
        .last  (rx_last ),
        .stats (rx_stats)
    );

    send_monitor #(
        .CNT_WIDTH (CNT_WIDTH)
    ) send_monitor_i (
        .clk   (clk     ),
        .rst_n (rst_n   ),
        .valid (tx_valid),
        .ready (tx_ready),
        .last  (tx_last ),
        .stats (tx_stats)
    );

    stat_regs #(
        .CNT_WIDTH (CNT_WIDTH)
    ) stat_regs_i (
        .clk     (clk     ),
        .rst_n   (rst_n   ),
        .psel    (psel    ),
        .penable (penable ),
        .pwrite  (pwrite  ),
        .paddr   (paddr   ),
        .pwdata  (pwdata  ),
        .prdata  (prdata  ),
        .pready  (pready  ),
        .pslverr (pslverr ),
        .rx      (rx_stats),
        .tx      (tx_stats)
    );

endmodule

//--- tests/cmac_stream_monitor_chk.sv
module cmac_stream_monitor_chk
    import cmac_mon_pkg::*;
#(
    parameter int CNT_WIDTH = cnt_width_default
)(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 psel,
    input logic                 penable,
    input logic                 pready,
    input logic                 pslverr,
    input logic                 rx_clear,
    input logic                 tx_clear,
    input logic [CNT_WIDTH-1:0] rx_pkt,
    input logic [CNT_WIDTH-1:0] tx_pkt
);

    // No wait states on the APB side
    assert property (@(posedge clk) disable iff (!rst_n) (psel && penable) |-> pready)
        else $error("pready low in an APB access cycle");

    assert property (@(posedge clk) disable iff (!rst_n) !(psel && penable) |-> !pslverr)
        else $error("pslverr high outside an APB access cycle");

    assert property (@(posedge clk) disable iff (!rst_n) rx_clear |=> !rx_clear)
        else $error("rx clear pulse longer than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n) tx_clear |=> !tx_clear)
        else $error("tx clear pulse longer than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n) rx_clear |=> (rx_pkt == '0))
        else $error("rx packet count not zero after clear");

    assert property (@(posedge clk) disable iff (!rst_n) tx_clear |=> (tx_pkt == '0))
        else $error("tx packet count not zero after clear");

endmodule

bind cmac_stream_monitor cmac_stream_monitor_chk #(
    .CNT_WIDTH (CNT_WIDTH)
) cmac_stream_monitor_chk_i (
    .clk      (clk                ),
    .rst_n    (rst_n              ),
    .psel     (psel               ),
    .penable  (penable            ),
    .pready   (pready             ),
    .pslverr  (pslverr            ),
    .rx_clear (rx_stats.clear     ),
    .tx_clear (tx_stats.clear     ),
    .rx_pkt   (rx_stats.pkt_count ),
    .tx_pkt   (tx_stats.pkt_count )
);

//--- tests/cmac_stream_monitor_tb.sv
module cmac_stream_monitor_tb
    import cmac_mon_pkg::*;
();

    localparam int clk_half     = 20;
    localparam int apb_timeout  = 16;
    localparam int idle_timeout = 16;

    typedef struct packed {
        logic [7:0] cycles;
        logic       rand_en;     // Random valid and ready on both sides
        logic [2:0] rx_bits;     // {valid, ready, last}
        logic [2:0] tx_bits;
        logic       chk_status;
        logic [1:0] status;      // {tx idle, rx idle}
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        rx_valid, rx_ready, rx_last;
    logic        tx_valid, tx_ready, tx_last;
    logic        psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    row_t        rows[$];
    string       row_names[$];
    logic [15:0] lfsr_state;
    int          mismatch_count;
    int          failure_count;

    // Reference counters
    logic [31:0] m_rx_pkt, m_rx_lost, m_rx_beats;
    logic [31:0] m_tx_pkt, m_tx_size, m_tx_beats, m_tx_run;
    logic        m_rx_idle, m_tx_idle;

    cmac_stream_monitor cmac_stream_monitor_i (
        .clk      (clk     ),
        .rst_n    (rst_n   ),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_last  (rx_last ),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_last  (tx_last ),
        .psel     (psel    ),
        .penable  (penable ),
        .pwrite   (pwrite  ),
        .paddr    (paddr   ),
        .pwdata   (pwdata  ),
        .prdata   (prdata  ),
        .pready   (pready  ),
        .pslverr  (pslverr )
    );

    always #clk_half clk = ~clk;

    always @(posedge clk) begin
        if (!rst_n) begin
            {m_rx_pkt, m_rx_lost, m_rx_beats} = '0;
            {m_tx_pkt, m_tx_size, m_tx_beats, m_tx_run} = '0;
            m_rx_idle = 1'b1;
            m_tx_idle = 1'b1;
        end else begin
            if (rx_valid && rx_ready && rx_last)
                m_rx_pkt = m_rx_pkt + 1;
            if (rx_valid && !rx_ready)
                m_rx_lost = m_rx_lost + 1;  // Receive path cannot stall
            if (rx_valid)
                m_rx_beats = m_rx_beats + 1;
            if (rx_valid && rx_ready)
                m_rx_idle = rx_last;
            if (tx_valid && tx_ready) begin
                m_tx_beats = m_tx_beats + 1;
                m_tx_idle  = tx_last;
                if (tx_last) begin
                    m_tx_pkt  = m_tx_pkt + 1;
                    m_tx_size = m_tx_run + 1;
                    m_tx_run  = 0;
                end else begin
                    m_tx_run = m_tx_run + 1;
                end
            end
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic random_bit();
        lfsr_state = {lfsr_state[14:0],
                      lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        return lfsr_state[0];
    endfunction

    task automatic add_row(input string name, input int cycles, input logic rand_en,
                           input logic [2:0] rx_bits, input logic [2:0] tx_bits,
                           input logic chk_status, input logic [1:0] status);
        row_t row;
        row.cycles     = cycles[7:0];
        row.rand_en    = rand_en;
        row.rx_bits    = rx_bits;
        row.tx_bits    = tx_bits;
        row.chk_status = chk_status;
        row.status     = status;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s expected 0x%08h actual 0x%08h",
                     test, what, expected, actual);
            mismatch_count++;
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(clk_half / 2);
        while (!pready && waits < apb_timeout) begin
            @(negedge clk);
            #(clk_half / 2);
            waits++;
        end
        assert (pready) else begin
            $display("APB access to address 0x%02h got no pready within %0d cycles",
                     addr, apb_timeout);
            failure_count++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
    endtask

    task automatic read_and_compare(input string test, input logic [7:0] addr,
                                    input string reg_name, input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_transfer(1'b0, addr, '0, data, err);
        check_value(test, reg_name, expected, data);
        check_value(test, {reg_name, " pslverr"}, 32'd0, {31'd0, err});
    endtask

    task automatic check_all_regs(input string test);
        read_and_compare(test, RX_PKT,   "RX_PKT",   m_rx_pkt);
        read_and_compare(test, RX_LOST,  "RX_LOST",  m_rx_lost);
        read_and_compare(test, RX_BEATS, "RX_BEATS", m_rx_beats);
        read_and_compare(test, TX_PKT,   "TX_PKT",   m_tx_pkt);
        read_and_compare(test, TX_SIZE,  "TX_SIZE",  m_tx_size);
        read_and_compare(test, TX_BEATS, "TX_BEATS", m_tx_beats);
        read_and_compare(test, STATUS,   "STATUS",   {30'd0, m_tx_idle, m_rx_idle});
    endtask

    task automatic wait_side_idle(input string test, input int side_bit);
        logic [31:0] data;
        logic        err;
        int          polls;
        polls = 0;
        apb_transfer(1'b0, STATUS, '0, data, err);
        while (!data[side_bit] && polls < idle_timeout) begin
            apb_transfer(1'b0, STATUS, '0, data, err);
            polls++;
        end
        assert (data[side_bit]) else begin
            $display("%s: STATUS bit %0d did not show idle within %0d reads",
                     test, side_bit, idle_timeout);
            failure_count++;
        end
    endtask

    task automatic apply_rows(input int first, input int last_row);
        logic [31:0] data;
        logic        err;
        for (int r = first; r <= last_row; r++) begin
            for (int c = 0; c < rows[r].cycles; c++) begin
                if (rows[r].rand_en) begin
                    rx_valid = random_bit();
                    rx_ready = random_bit();
                    tx_valid = random_bit();
                    tx_ready = random_bit();
                    rx_last  = rows[r].rx_bits[0];
                    tx_last  = rows[r].tx_bits[0];
                end else begin
                    {rx_valid, rx_ready, rx_last} = rows[r].rx_bits;
                    {tx_valid, tx_ready, tx_last} = rows[r].tx_bits;
                end
                @(negedge clk);
            end
            {rx_valid, rx_ready, rx_last} = 3'b000;
            {tx_valid, tx_ready, tx_last} = 3'b000;
            check_all_regs(row_names[r]);
            if (rows[r].chk_status) begin
                apply_status_check: begin
                    apb_transfer(1'b0, STATUS, '0, data, err);
                    check_value(row_names[r], "STATUS from table", {30'd0, rows[r].status}, data);
                end
            end
        end
    endtask

    task automatic clear_side(input string test, input int side_bit);
        logic [31:0] data;
        logic        err;
        apb_transfer(1'b1, CTRL, 32'd1 << side_bit, data, err);
        check_value(test, "CTRL write pslverr", 32'd0, {31'd0, err});
        wait_side_idle(test, side_bit);
        if (side_bit == ctrl_clear_rx_bit) begin
            {m_rx_pkt, m_rx_lost, m_rx_beats} = '0;
            m_rx_idle = 1'b1;
        end else begin
            {m_tx_pkt, m_tx_size, m_tx_beats, m_tx_run} = '0;
            m_tx_idle = 1'b1;
        end
        check_all_regs(test);
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        clk = 1'b0;
        rst_n = 1'b0;
        {rx_valid, rx_ready, rx_last} = 3'b000;
        {tx_valid, tx_ready, tx_last} = 3'b000;
        {psel, penable, pwrite} = 3'b000;
        paddr = '0;
        pwdata = '0;
        lfsr_state = 16'd9;
        mismatch_count = 0;
        failure_count = 0;
        {m_rx_pkt, m_rx_lost, m_rx_beats} = '0;
        {m_tx_pkt, m_tx_size, m_tx_beats, m_tx_run} = '0;
        m_rx_idle = 1'b1;
        m_tx_idle = 1'b1;

        //       name           cyc rand rx      tx      chk stat
        add_row("both_body",    3,  0, 3'b110, 3'b110, 1, 2'b00);
        add_row("both_tail",    1,  0, 3'b111, 3'b111, 1, 2'b11);
        add_row("rx_lost",      4,  0, 3'b100, 3'b000, 1, 2'b11);
        add_row("tx_stall",     2,  0, 3'b000, 3'b101, 1, 2'b11);
        add_row("tx_short",     2,  0, 3'b000, 3'b110, 1, 2'b01);
        add_row("tx_end",       1,  0, 3'b000, 3'b111, 1, 2'b11);
        add_row("rx_open",      2,  0, 3'b110, 3'b000, 1, 2'b10);
        add_row("rand_single",  40, 1, 3'b001, 3'b001, 0, 2'b00);
        add_row("rand_open",    40, 1, 3'b000, 3'b000, 0, 2'b00);
        add_row("both_close",   1,  0, 3'b111, 3'b111, 1, 2'b11);
        add_row("rx_hold",      2,  0, 3'b110, 3'b000, 1, 2'b10);
        add_row("rx_refill",    3,  0, 3'b111, 3'b000, 1, 2'b11);
        add_row("tx_hold",      2,  0, 3'b000, 3'b110, 1, 2'b01);
        add_row("tx_restart",   1,  0, 3'b000, 3'b111, 1, 2'b11);

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_all_regs("after_reset");

        // Each side is mid-packet when its clear arrives
        apply_rows(0, 10);
        clear_side("clear_rx", ctrl_clear_rx_bit);
        apply_rows(11, 12);
        clear_side("clear_tx", ctrl_clear_tx_bit);
        apply_rows(13, 13);

        // Unmapped read and illegal write must not touch any counter
        apb_transfer(1'b0, 8'h20, '0, data, err);
        check_value("bad_addr", "pslverr", 32'd1, {31'd0, err});
        check_value("bad_addr", "prdata", 32'd0, data);
        apb_transfer(1'b1, RX_PKT, 32'hFFFF_FFFF, data, err);
        check_value("bad_write", "pslverr", 32'd1, {31'd0, err});
        check_all_regs("bad_access");

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- cmac_stream_monitor.f
common/cmac_mon_pkg.sv
common/mon_stats_if.sv
stream_monitor/recv_monitor.sv
stream_monitor/send_monitor.sv
hw/stat_regs.sv
hw/cmac_stream_monitor.sv
tests/cmac_stream_monitor_chk.sv
tests/cmac_stream_monitor_tb.sv
